// ==== common/uart_link_pkg.sv ====
/*
 * uart string link package
 * serial timing, frame and fifo constants, the fifo entry type
 * and the state encodings shared by the link blocks
 */
package uart_link_pkg;

	// serial timing
	localparam int CLKS_PER_BIT = 16;
	localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

	// baud counter compare points
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_W-1:0] BIT_MID  = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// frame format, ampersand delimiters
	localparam logic [7:0] FRAME_DELIM = 8'h26;
	localparam int         LEN_W       = 6;

	// payload bytes beyond this are dropped
	localparam logic [LEN_W-1:0] MAX_PAYLOAD = LEN_W'(32);

	// byte fifo geometry
	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_AW    = 6;

	// one stored payload byte, last marks the end of a frame
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} fifo_entry_t;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

	typedef enum logic [2:0] {
		DEC_HUNT,
		DEC_OPEN,
		DEC_PAYLOAD,
		DEC_CLOSE,
		DEC_SPILL
	} dec_state_e;

	typedef enum logic [1:0] {
		ENC_IDLE,
		ENC_HEAD,
		ENC_BODY,
		ENC_TAIL
	} enc_state_e;

endpackage

// ==== dv/tb_uart_string_link.sv ====
/*
 * uart string link testbench
 * drives framed and unframed serial traffic into the link, decodes the
 * echo on the transmit line and compares it with a framing model
 */
`timescale 1ns/10ps

module tb_uart_string_link;

	typedef logic [7:0] byte_q_t[$];
	typedef int         int_q_t[$];

	logic                            sys_clk;
	logic                            sys_rst_n;
	logic                            uart_rx_port;
	logic                            uart_tx_port;
	logic                            rx_done;
	logic [uart_link_pkg::LEN_W-1:0] rx_length;
	logic                            tx_busy;
	logic                            fifo_full;

	integer   seed = 32'hfde55f8c;
	byte_q_t  sent;
	byte_q_t  exp_echo;
	int_q_t   exp_len;
	byte_q_t  mon_q;
	int       echo_total;
	int       len_total;
	int       echo_seen = 0;
	int       len_seen = 0;
	int       err_cnt = 0;
	int       limit_cycles = 0;
	logic     stim_ready = 1'b0;

	uart_string_link i_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.rx_done      (rx_done),
		.rx_length    (rx_length),
		.tx_busy      (tx_busy),
		.fifo_full    (fifo_full)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("[ERROR] %0t %s", $time, why);
		$display("CHECKS FAILED");
		$fatal(1, "run aborted");
	endtask

	// expected frame lengths and echo stream from the delimiter rules
	function automatic void model_link(input byte_q_t stream, output byte_q_t echo,
		output int_q_t lens);
		int         st;
		int         max_pay;
		byte_q_t    pay;
		logic [7:0] b;
		echo = {};
		lens = {};
		pay = {};
		st = 0;
		max_pay = int'(uart_link_pkg::MAX_PAYLOAD);
		foreach (stream[i]) begin
			b = stream[i];
			case (st)
				// hunt
				0: if (b == uart_link_pkg::FRAME_DELIM)
					st = 1;
				// open
				1: begin
					st = (b == uart_link_pkg::FRAME_DELIM) ? 2 : 0;
					pay = {};
				end
				// payload
				2: if (b == uart_link_pkg::FRAME_DELIM)
					st = 3;
				else if (pay.size() < max_pay)
					pay.push_back(b);
				// close, a lone ampersand belongs to the payload
				default: if (b == uart_link_pkg::FRAME_DELIM) begin
					if (pay.size() > 0) begin
						lens.push_back(pay.size());
						echo.push_back(uart_link_pkg::FRAME_DELIM);
						echo.push_back(uart_link_pkg::FRAME_DELIM);
						foreach (pay[j])
							echo.push_back(pay[j]);
						echo.push_back(uart_link_pkg::FRAME_DELIM);
						echo.push_back(uart_link_pkg::FRAME_DELIM);
					end
					st = 0;
				end else begin
					if (pay.size() < max_pay)
						pay.push_back(uart_link_pkg::FRAME_DELIM);
					if (pay.size() < max_pay)
						pay.push_back(b);
					st = 2;
				end
			endcase
		end
	endfunction

	task automatic add_text(input string s);
		for (int i = 0; i < s.len(); i++)
			sent.push_back(s[i]);
	endtask

	// random bytes that never form a delimiter
	task automatic add_noise(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = 8'($random(seed));
			if (b == uart_link_pkg::FRAME_DELIM)
				b = 8'h55;
			sent.push_back(b);
		end
	endtask

	task automatic add_random_frame(input int n);
		add_text("&&");
		add_noise(n);
		add_text("&&");
	endtask

	// 8N1, lsb first, bits change just after the rising edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			#1;
			uart_rx_port = bits[i];
			repeat (uart_link_pkg::CLKS_PER_BIT - 1) @(posedge sys_clk);
		end
	endtask

	// transmit line decoder, samples on the falling edge
	initial begin
		logic [7:0] data;
		forever begin
			@(negedge sys_clk);
			if (uart_tx_port === 1'b0) begin
				repeat (uart_link_pkg::CLKS_PER_BIT / 2) @(negedge sys_clk);
				if (uart_tx_port !== 1'b0)
					abort_run("start bit on the transmit line did not last to mid-bit");
				for (int i = 0; i < 8; i++) begin
					repeat (uart_link_pkg::CLKS_PER_BIT) @(negedge sys_clk);
					data[i] = uart_tx_port;
				end
				repeat (uart_link_pkg::CLKS_PER_BIT) @(negedge sys_clk);
				if (uart_tx_port !== 1'b1)
					abort_run("missing stop bit on the transmit line");
				mon_q.push_back(data);
			end
		end
	end

	// compares frame reports and echoed bytes against the model
	initial begin
		logic [7:0] got_b;
		forever begin
			@(negedge sys_clk);
			// traffic never comes close to the fifo depth
			if (sys_rst_n === 1'b1)
				check_value(32'(fifo_full), 32'd0, "fifo_full");
			if (rx_done === 1'b1) begin
				if (exp_len.size() == 0)
					abort_run("rx_done pulsed although no frame was expected");
				check_value(32'(rx_length), 32'(exp_len.pop_front()), "rx_length");
				len_seen++;
			end
			while (mon_q.size() > 0) begin
				got_b = mon_q.pop_front();
				if (exp_echo.size() == 0)
					abort_run("transmit line sent a byte beyond the expected echo");
				check_value(32'(got_b), 32'(exp_echo.pop_front()), "echo byte");
				echo_seen++;
			end
		end
	end

	initial begin
		wait (stim_ready);
		repeat (limit_cycles) @(posedge sys_clk);
		$display("[ERROR] %0t watchdog expired before the echo completed", $time);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		uart_rx_port = 1'b1;
		sys_rst_n    = 1'b0;

		// single frame, then noise and a broken opening
		add_text("&&hello uart&&");
		add_noise(6);
		add_text("&x");
		add_noise(3);
		// lone ampersand in the payload, then an empty frame
		add_text("&&ab&cd&&");
		add_text("&&&&");
		// longer than the payload limit
		add_random_frame(40);
		// back-to-back frames
		add_random_frame(1);
		add_random_frame(5);
		add_random_frame(8);

		model_link(sent, exp_echo, exp_len);
		echo_total   = exp_echo.size();
		len_total    = exp_len.size();
		limit_cycles = sent.size() * 10 * uart_link_pkg::CLKS_PER_BIT * 3 + 4000;
		stim_ready   = 1'b1;
		$display("sending %0d bytes, expecting %0d frames and %0d echo bytes",
			sent.size(), len_total, echo_total);

		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;

		@(negedge sys_clk);
		check_value(32'(uart_tx_port), 32'd1, "idle transmit line after reset");
		check_value(32'(rx_done), 32'd0, "rx_done after reset");
		check_value(32'(tx_busy), 32'd0, "tx_busy after reset");
		check_value(32'(fifo_full), 32'd0, "fifo_full after reset");

		foreach (sent[i])
			send_byte(sent[i]);

		while (echo_seen < echo_total)
			@(negedge sys_clk);
		while (tx_busy === 1'b1)
			@(negedge sys_clk);
		// quiet period to catch stray output
		repeat (4 * 10 * uart_link_pkg::CLKS_PER_BIT) @(negedge sys_clk);

		check_value(32'(len_seen), 32'(len_total), "rx_done count");
		check_value(32'(tx_busy), 32'd0, "tx_busy at the end");
		check_value(32'(uart_tx_port), 32'd1, "idle transmit line at the end");

		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "errors found");
		end
	end

endmodule

// ==== logic/byte_fifo.sv ====
/*
 * byte fifo
 * ring buffer of payload entries between decoder and encoder
 */
`timescale 1ns/10ps

module byte_fifo (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        wr_en,
	input  uart_link_pkg::fifo_entry_t  wr_entry,
	input  logic                        rd_ready,
	output logic                        full,
	output uart_link_pkg::fifo_entry_t  rd_entry,
	output logic                        rd_valid
);

	uart_link_pkg::fifo_entry_t           mem [uart_link_pkg::FIFO_DEPTH];
	logic [uart_link_pkg::FIFO_AW:0]      wr_ptr;
	logic [uart_link_pkg::FIFO_AW:0]      rd_ptr;
	logic                                 do_wr;
	logic                                 do_rd;

	// extra pointer bit tells full from empty
	assign full = (wr_ptr[uart_link_pkg::FIFO_AW] != rd_ptr[uart_link_pkg::FIFO_AW]) &&
		(wr_ptr[uart_link_pkg::FIFO_AW-1:0] == rd_ptr[uart_link_pkg::FIFO_AW-1:0]);
	assign rd_valid = (wr_ptr != rd_ptr);
	assign rd_entry = mem[rd_ptr[uart_link_pkg::FIFO_AW-1:0]];

	// writes while full are lost
	assign do_wr = wr_en && !full;
	assign do_rd = rd_ready && rd_valid;

	always_ff @(posedge sys_clk) begin
		if (do_wr)
			mem[wr_ptr[uart_link_pkg::FIFO_AW-1:0]] <= wr_entry;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// ==== logic/frame_decoder.sv ====
/*
 * frame decoder
 * finds &&payload&& frames in the received byte stream, writes
 * the payload into the fifo and reports each frame's length
 */
`timescale 1ns/10ps

module frame_decoder (
	input  logic                                sys_clk,
	input  logic                                sys_rst_n,
	input  logic [7:0]                          rx_byte,
	input  logic                                rx_vld,
	output logic                                wr_en,
	output uart_link_pkg::fifo_entry_t          wr_entry,
	output logic                                rx_done,
	output logic [uart_link_pkg::LEN_W-1:0]     rx_length
);

	uart_link_pkg::dec_state_e            state;
	logic [7:0]                           pend_byte;
	logic                                 pend_vld;
	logic [7:0]                           spill_byte;
	logic [uart_link_pkg::LEN_W-1:0]      pay_cnt;
	logic                                 is_delim;
	logic                                 acc_req;
	logic [7:0]                           acc_byte;
	logic                                 accept;
	logic                                 frame_end;

	assign is_delim = (rx_byte == uart_link_pkg::FRAME_DELIM);

	// byte offered to the payload this cycle
	always_comb begin
		acc_req  = 1'b0;
		acc_byte = rx_byte;
		case (state)
			uart_link_pkg::DEC_PAYLOAD: acc_req = rx_vld && !is_delim;
			uart_link_pkg::DEC_CLOSE: begin
				// lone ampersand turns out to be payload
				acc_req  = rx_vld && !is_delim;
				acc_byte = uart_link_pkg::FRAME_DELIM;
			end
			uart_link_pkg::DEC_SPILL: begin
				acc_req  = 1'b1;
				acc_byte = spill_byte;
			end
			default: acc_req = 1'b0;
		endcase
	end

	assign accept    = acc_req && (pay_cnt < uart_link_pkg::MAX_PAYLOAD);
	assign frame_end = (state == uart_link_pkg::DEC_CLOSE) && rx_vld && is_delim;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			state <= uart_link_pkg::DEC_HUNT;
		else begin
			case (state)
				uart_link_pkg::DEC_HUNT:
					if (rx_vld && is_delim)
						state <= uart_link_pkg::DEC_OPEN;
				uart_link_pkg::DEC_OPEN:
					if (rx_vld)
						state <= is_delim ? uart_link_pkg::DEC_PAYLOAD : uart_link_pkg::DEC_HUNT;
				uart_link_pkg::DEC_PAYLOAD:
					if (rx_vld && is_delim)
						state <= uart_link_pkg::DEC_CLOSE;
				uart_link_pkg::DEC_CLOSE:
					if (rx_vld)
						state <= is_delim ? uart_link_pkg::DEC_HUNT : uart_link_pkg::DEC_SPILL;
				default: state <= uart_link_pkg::DEC_PAYLOAD;
			endcase
		end
	end

	// pending byte tracking and payload count
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pend_vld <= 1'b0;
			pay_cnt  <= '0;
		end else if (frame_end) begin
			pend_vld <= 1'b0;
			pay_cnt  <= '0;
		end else if (accept) begin
			pend_vld <= 1'b1;
			pay_cnt  <= pay_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			pend_byte <= acc_byte;
		if (state == uart_link_pkg::DEC_CLOSE && rx_vld && !is_delim)
			spill_byte <= rx_byte;
		if (accept || frame_end) begin
			wr_entry.data <= pend_byte;
			wr_entry.last <= frame_end;
		end
	end

	// pending byte goes out when displaced or when the frame closes
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_en     <= 1'b0;
			rx_done   <= 1'b0;
			rx_length <= '0;
		end else begin
			wr_en     <= pend_vld && (accept || frame_end);
			rx_done   <= pend_vld && frame_end;
			rx_length <= (pend_vld && frame_end) ? pay_cnt : '0;
		end
	end

endmodule

// ==== logic/frame_encoder.sv ====
/*
 * frame encoder
 * pops stored payload bytes and sends them wrapped in && .. &&
 * through the uart transmitter
 */
`timescale 1ns/10ps

module frame_encoder (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  uart_link_pkg::fifo_entry_t  rd_entry,
	input  logic                        rd_valid,
	input  logic                        tx_done,
	output logic                        rd_ready,
	output logic [7:0]                  tx_data,
	output logic                        tx_req,
	output logic                        tx_busy
);

	uart_link_pkg::enc_state_e  state;
	logic                       delim_cnt;
	logic                       tx_wait;
	logic                       sent_last;
	logic                       pop;

	assign tx_busy  = (state != uart_link_pkg::ENC_IDLE);
	// one entry per byte time, none after the last of the frame
	assign rd_ready = (state == uart_link_pkg::ENC_BODY) && !tx_wait && !sent_last;
	assign pop      = rd_ready && rd_valid;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= uart_link_pkg::ENC_IDLE;
			delim_cnt <= 1'b0;
			tx_wait   <= 1'b0;
			sent_last <= 1'b0;
			tx_req    <= 1'b0;
		end else begin
			tx_req <= 1'b0;
			if (tx_done)
				tx_wait <= 1'b0;
			case (state)
				uart_link_pkg::ENC_IDLE:
					if (rd_valid) begin
						state     <= uart_link_pkg::ENC_HEAD;
						delim_cnt <= 1'b0;
						tx_req    <= 1'b1;
						tx_wait   <= 1'b1;
					end
				uart_link_pkg::ENC_BODY:
					if (pop) begin
						tx_req    <= 1'b1;
						tx_wait   <= 1'b1;
						sent_last <= rd_entry.last;
					end else if (tx_done && sent_last) begin
						// last payload byte is out, start the closing pair
						sent_last <= 1'b0;
						delim_cnt <= 1'b0;
						state     <= uart_link_pkg::ENC_TAIL;
						tx_req    <= 1'b1;
						tx_wait   <= 1'b1;
					end
				default:
					// head and tail each send two delimiters
					if (tx_done) begin
						if (!delim_cnt) begin
							delim_cnt <= 1'b1;
							tx_req    <= 1'b1;
							tx_wait   <= 1'b1;
						end else begin
							delim_cnt <= 1'b0;
							state     <= (state == uart_link_pkg::ENC_HEAD) ?
								uart_link_pkg::ENC_BODY : uart_link_pkg::ENC_IDLE;
						end
					end
			endcase
		end
	end

	// payload byte on a pop, otherwise the delimiter
	always_ff @(posedge sys_clk) begin
		if (pop)
			tx_data <= rd_entry.data;
		else
			tx_data <= uart_link_pkg::FRAME_DELIM;
	end

endmodule

// ==== logic/uart_string_link.sv ====
/*
 * uart string link top
 * receiver, frame decoder, byte fifo, frame encoder and transmitter
 */
`timescale 1ns/10ps

module uart_string_link (
	input  logic                            sys_clk,
	input  logic                            sys_rst_n,
	input  logic                            uart_rx_port,
	output logic                            uart_tx_port,
	output logic                            rx_done,
	output logic [uart_link_pkg::LEN_W-1:0] rx_length,
	output logic                            tx_busy,
	output logic                            fifo_full
);

	logic [7:0]                  rx_byte;
	logic                        rx_vld;
	logic                        wr_en;
	uart_link_pkg::fifo_entry_t  wr_entry;
	uart_link_pkg::fifo_entry_t  rd_entry;
	logic                        rd_valid;
	logic                        rd_ready;
	logic [7:0]                  tx_data;
	logic                        tx_req;
	logic                        tx_done;

	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_decoder i_frame_decoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.wr_en     (wr_en),
		.wr_entry  (wr_entry),
		.rx_done   (rx_done),
		.rx_length (rx_length)
	);

	byte_fifo i_byte_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr_en     (wr_en),
		.wr_entry  (wr_entry),
		.rd_ready  (rd_ready),
		.full      (fifo_full),
		.rd_entry  (rd_entry),
		.rd_valid  (rd_valid)
	);

	frame_encoder i_frame_encoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rd_entry  (rd_entry),
		.rd_valid  (rd_valid),
		.tx_done   (tx_done),
		.rd_ready  (rd_ready),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy)
	);

	uart_tx i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.tx        (uart_tx_port),
		.tx_done   (tx_done)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uart string link testbench with Verilator

cd "$(dirname "$0")" \
	&& verilator --binary --timing -f verilog.f \
		--top-module tb_uart_string_link -o tb_sim \
	&& ./obj_dir/tb_sim \
	|| { echo "simulation failed"; exit 1; }

echo "simulation finished"

// ==== uart/uart_rx.sv ====
/*
 * uart receiver
 * 8N1 serial input sampled at mid-bit, one byte per rx_vld pulse
 */
`timescale 1ns/10ps

module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_vld
);

	logic [1:0]                           rx_sync;
	logic                                 rx_s;
	uart_link_pkg::uart_state_e           state;
	logic [uart_link_pkg::BIT_CNT_W-1:0]  baud_cnt;
	logic [2:0]                           bit_idx;
	logic [7:0]                           shift_reg;

	assign rx_s    = rx_sync[1];
	assign rx_byte = shift_reg;

	// two-flop synchronizer, idles high like the line
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], rx};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= uart_link_pkg::UART_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				uart_link_pkg::UART_IDLE: begin
					baud_cnt <= '0;
					bit_idx  <= '0;
					if (!rx_s)
						state <= uart_link_pkg::UART_START;
				end
				uart_link_pkg::UART_START: begin
					// confirm start bit at its middle, else treat as a glitch
					if (baud_cnt == uart_link_pkg::BIT_MID) begin
						baud_cnt <= '0;
						state    <= rx_s ? uart_link_pkg::UART_IDLE : uart_link_pkg::UART_DATA;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				uart_link_pkg::UART_DATA: begin
					if (baud_cnt == uart_link_pkg::BIT_LAST) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= uart_link_pkg::UART_STOP;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				uart_link_pkg::UART_STOP: begin
					// bad stop bit drops the byte
					if (baud_cnt == uart_link_pkg::BIT_LAST) begin
						state  <= uart_link_pkg::UART_IDLE;
						rx_vld <= rx_s;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default: state <= uart_link_pkg::UART_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge sys_clk) begin
		if (state == uart_link_pkg::UART_DATA && baud_cnt == uart_link_pkg::BIT_LAST)
			shift_reg <= {rx_s, shift_reg[7:1]};
	end

endmodule

// ==== uart/uart_tx.sv ====
/*
 * uart transmitter
 * sends one 8N1 byte per tx_req, tx_done pulses after the stop bit
 */
`timescale 1ns/10ps

module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_req,
	output logic       tx,
	output logic       tx_done
);

	uart_link_pkg::uart_state_e           state;
	logic [uart_link_pkg::BIT_CNT_W-1:0]  baud_cnt;
	logic [2:0]                           bit_idx;
	logic [7:0]                           shift_reg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= uart_link_pkg::UART_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			tx       <= 1'b1;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (state == uart_link_pkg::UART_IDLE) begin
				baud_cnt <= '0;
				bit_idx  <= '0;
				if (tx_req) begin
					state <= uart_link_pkg::UART_START;
					tx    <= 1'b0;
				end
			end else if (baud_cnt != uart_link_pkg::BIT_LAST) begin
				baud_cnt <= baud_cnt + 1'b1;
			end else begin
				// bit boundary
				baud_cnt <= '0;
				case (state)
					uart_link_pkg::UART_START: begin
						state <= uart_link_pkg::UART_DATA;
						tx    <= shift_reg[0];
					end
					uart_link_pkg::UART_DATA: begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= uart_link_pkg::UART_STOP;
							tx    <= 1'b1;
						end else
							tx <= shift_reg[1];
					end
					default: begin
						state   <= uart_link_pkg::UART_IDLE;
						tx_done <= 1'b1;
					end
				endcase
			end
		end
	end

	// byte latched on request, shifted out lsb first
	always_ff @(posedge sys_clk) begin
		if (state == uart_link_pkg::UART_IDLE && tx_req)
			shift_reg <= tx_data;
		else if (state == uart_link_pkg::UART_DATA && baud_cnt == uart_link_pkg::BIT_LAST)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

endmodule

// ==== verilog.f ====
common/uart_link_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/frame_decoder.sv
logic/byte_fifo.sv
logic/frame_encoder.sv
logic/uart_string_link.sv
dv/tb_uart_string_link.sv
